// File: build.f
+incdir+logic
logic/spi_word_pkg.sv
logic/spi_ctrl_pkg.sv
logic/spi_sck_if.sv
logic/spi_sck_gen.sv
logic/spi_master.sv
logic/spi_top.sv
verif/spi_slave_model.sv
verif/spi_tb.sv

// File: verif/spi_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_defs.svh"

module spi_tb;

	import spi_word_pkg::*;

	localparam int WIDTH     = `SPI_WIDTH;
	localparam int DIV       = `SPI_DIV;
	localparam int FRAME_CYC = 2 * WIDTH * DIV + 2;
	localparam int N_TESTS   = 12;
	localparam int WDOG_NS   = (N_TESTS + 2) * 140 * 20;

	logic      CLK50MHZ;
	logic      RST;
	logic      trig;
	spi_word_t data_in;
	spi_word_t data_out;
	logic      done;
	logic      spi_sck;
	logic      spi_cs;
	logic      spi_mosi;
	logic      spi_miso;
	spi_word_t tx_word;
	spi_word_t rx_word;

	// Stimulus table: master word, slave word, mid-frame trigger
	spi_word_t master_tab [N_TESTS];
	spi_word_t slave_tab  [N_TESTS];
	bit        extra_tab  [N_TESTS];

	integer seed;
	int     err_cnt;
	int     pass_cnt;
	int     fail_cnt;
	int     cs_falls;
	int     sck_rises;
	int     done_cnt;
	logic   done_prev;

	spi_top #(
		.WIDTH(WIDTH),
		.DIV(DIV)
	) dut0 (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.trig     (trig),
		.data_in  (data_in),
		.data_out (data_out),
		.done     (done),
		.spi_sck  (spi_sck),
		.spi_cs   (spi_cs),
		.spi_mosi (spi_mosi),
		.spi_miso (spi_miso)
	);

	spi_slave_model #(
		.WIDTH(WIDTH)
	) slave0 (
		.spi_sck  (spi_sck),
		.spi_cs   (spi_cs),
		.spi_mosi (spi_mosi),
		.spi_miso (spi_miso),
		.tx_word  (tx_word),
		.rx_word  (rx_word)
	);

	initial begin
		CLK50MHZ = 1'b0;
	end

	always #10 CLK50MHZ = ~CLK50MHZ;

	////////////////////////////////////////////////////////////
	// Framing monitor
	////////////////////////////////////////////////////////////

	always @(negedge spi_cs) cs_falls++;

	always @(posedge done) done_cnt++;

	// Only SCK rises inside a frame count
	always @(posedge spi_sck) begin
		if (spi_cs === 1'b0) begin
			sck_rises++;
		end
	end

	always @(negedge CLK50MHZ) begin
		if (RST === 1'b0) begin
			if (spi_cs === 1'b1 && spi_sck !== 1'b0) begin
				$display("Error at %0t: spi_sck high while spi_cs is high", $time);
				err_cnt++;
			end
			if (done === 1'b1 && done_prev === 1'b1) begin
				$display("Error at %0t: done wider than one cycle", $time);
				err_cnt++;
			end
		end
		done_prev = done;
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	task automatic fill_table();
		begin
			master_tab[0] = '0;
			slave_tab[0]  = '1;
			extra_tab[0]  = 1'b0;
			master_tab[1] = '1;
			slave_tab[1]  = '0;
			extra_tab[1]  = 1'b0;
			master_tab[2] = 32'hA5A5_5A5A;
			slave_tab[2]  = 32'h8000_0001;
			extra_tab[2]  = 1'b1;
			master_tab[3] = 32'h8000_0001;
			slave_tab[3]  = 32'hA5A5_5A5A;
			extra_tab[3]  = 1'b0;
			for (int i = 4; i < N_TESTS; i++) begin
				master_tab[i] = $random(seed);
				slave_tab[i]  = $random(seed);
				extra_tab[i]  = $random(seed) & 1;
			end
		end
	endtask

	task automatic check_idle_levels(input string when);
		begin
			if (spi_cs !== 1'b1 || spi_sck !== 1'b0 || spi_mosi !== 1'b0 ||
				done !== 1'b0 || data_out !== '0) begin
				$display("Error at %0t: bad idle levels %s cs=%b sck=%b mosi=%b done=%b",
					$time, when, spi_cs, spi_sck, spi_mosi, done);
				err_cnt++;
			end
		end
	endtask

	// CS must come back high and stay there with MOSI low
	task automatic wait_cs_release(input int idx);
		int n;
		begin
			n = 0;
			while (spi_cs !== 1'b1 && n < 4) begin
				@(negedge CLK50MHZ);
				n++;
			end
			if (spi_cs !== 1'b1) begin
				$display("Frame %0d: chip select did not return high after done", idx);
				err_cnt++;
			end else begin
				repeat (3) begin
					@(negedge CLK50MHZ);
					if (spi_cs !== 1'b1 || spi_mosi !== 1'b0) begin
						$display("Error at %0t: frame %0d cs=%b mosi=%b after release",
							$time, idx, spi_cs, spi_mosi);
						err_cnt++;
					end
				end
			end
		end
	endtask

	task automatic run_frame(input int idx, input bit next_b2b);
		int cycles;
		bit got;
		int err0;
		int cs0;
		int sck0;
		int done0;
		begin
			err0  = err_cnt;
			cs0   = cs_falls;
			sck0  = sck_rises;
			done0 = done_cnt;
			@(posedge CLK50MHZ);
			trig    <= 1'b1;
			data_in <= master_tab[idx];
			tx_word <= slave_tab[idx];
			cycles = 0;
			got    = 1'b0;
			while (!got && cycles < FRAME_CYC + 20) begin
				@(posedge CLK50MHZ);
				// Busy trigger in the middle of the frame
				trig <= extra_tab[idx] && (cycles == FRAME_CYC / 2);
				@(negedge CLK50MHZ);
				cycles++;
				if (done === 1'b1) begin
					got = 1'b1;
				end
			end
			if (!got) begin
				$display("Frame %0d: no done pulse within %0d cycles", idx, cycles);
				err_cnt++;
			end else begin
				if (cycles != FRAME_CYC) begin
					$display("Error at %0t: frame %0d took %0d cycles, expected %0d",
						$time, idx, cycles, FRAME_CYC);
					err_cnt++;
				end
				if (data_out !== slave_tab[idx]) begin
					$display("Error at %0t: frame %0d data_out %h, expected %h",
						$time, idx, data_out, slave_tab[idx]);
					err_cnt++;
				end
				if (rx_word !== master_tab[idx]) begin
					$display("Error at %0t: frame %0d slave saw %h, expected %h",
						$time, idx, rx_word, master_tab[idx]);
					err_cnt++;
				end
				if (cs_falls - cs0 != 1) begin
					$display("Frame %0d: expected one chip select low period, saw %0d",
						idx, cs_falls - cs0);
					err_cnt++;
				end
				if (sck_rises - sck0 != WIDTH) begin
					$display("Error at %0t: frame %0d had %0d SCK rises, expected %0d",
						$time, idx, sck_rises - sck0, WIDTH);
					err_cnt++;
				end
				if (done_cnt - done0 != 1) begin
					$display("Error at %0t: frame %0d had %0d done pulses",
						$time, idx, done_cnt - done0);
					err_cnt++;
				end
			end
			// Back-to-back frames start right away, CS is checked later
			if (!next_b2b) begin
				wait_cs_release(idx);
			end
			if (err_cnt == err0) begin
				pass_cnt++;
				$display("Frame %0d master %h slave %h: pass", idx,
					master_tab[idx], slave_tab[idx]);
			end else begin
				fail_cnt++;
				$display("Frame %0d master %h slave %h: FAIL", idx,
					master_tab[idx], slave_tab[idx]);
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int err0;
		RST       = 1'b1;
		trig      = 1'b0;
		data_in   = '0;
		tx_word   = '0;
		seed      = 32'hb153;
		err_cnt   = 0;
		pass_cnt  = 0;
		fail_cnt  = 0;
		cs_falls  = 0;
		sck_rises = 0;
		done_cnt  = 0;
		done_prev = 1'b0;
		fill_table();

		// Ten reset cycles, levels checked inside and after
		err0 = err_cnt;
		repeat (2) @(negedge CLK50MHZ);
		check_idle_levels("during reset");
		repeat (8) @(posedge CLK50MHZ);
		RST <= 1'b0;
		repeat (2) @(negedge CLK50MHZ);
		check_idle_levels("after reset");
		if (err_cnt == err0) begin
			pass_cnt++;
			$display("Reset levels: pass");
		end else begin
			fail_cnt++;
			$display("Reset levels: FAIL");
		end

		// Last two entries follow the previous done by one cycle
		for (int i = 0; i < N_TESTS; i++) begin
			run_frame(i, (i == N_TESTS - 3) || (i == N_TESTS - 2));
		end

		@(posedge CLK50MHZ);
		$display("Summary: %0d passed, %0d not passed, %0d check errors",
			pass_cnt, fail_cnt, err_cnt);
		if (fail_cnt == 0 && err_cnt == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// Hang guard sized from the number of frames
	initial begin
		#(WDOG_NS);
		$display("Watchdog expired after %0d ns, the run hung", WDOG_NS);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/spi_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_defs.svh"

module spi_slave_model #(
	parameter int WIDTH = `SPI_WIDTH
) (
	input  logic             spi_sck,
	input  logic             spi_cs,
	input  logic             spi_mosi,
	output logic             spi_miso,

	// Word to send back, and the word seen on MOSI
	input  logic [WIDTH-1:0] tx_word,
	output logic [WIDTH-1:0] rx_word
);

	logic [WIDTH-1:0] tx_sh;

	initial begin
		spi_miso = 1'b0;
		rx_word  = '0;
		tx_sh    = '0;
	end

	////////////////////////////////////////////////////////////
	// Mode 0 slave behavior
	////////////////////////////////////////////////////////////

	// First bit must be on MISO before the first SCK rise
	always @(negedge spi_cs) begin
		tx_sh    = tx_word;
		rx_word  = '0;
		spi_miso = tx_word[WIDTH-1];
	end

	// Sample MOSI on rising SCK, MSB first
	always @(posedge spi_sck) begin
		if (spi_cs === 1'b0) begin
			rx_word = {rx_word[WIDTH-2:0], spi_mosi};
		end
	end

	// Next bit goes out on falling SCK
	always @(negedge spi_sck) begin
		if (spi_cs === 1'b0) begin
			tx_sh    = {tx_sh[WIDTH-2:0], 1'b0};
			spi_miso = tx_sh[WIDTH-1];
		end
	end

	// Park MISO low between frames
	always @(posedge spi_cs) begin
		spi_miso = 1'b0;
	end

endmodule

`default_nettype wire

// File: logic/spi_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_defs.svh"

module spi_top #(
	parameter int WIDTH = `SPI_WIDTH,
	parameter int DIV   = `SPI_DIV
) (
	input  logic                    CLK50MHZ,
	input  logic                    RST,

	// User side
	input  logic                    trig,
	input  spi_word_pkg::spi_word_t data_in,
	output spi_word_pkg::spi_word_t data_out,
	output logic                    done,

	// Serial lines to the slave
	output logic                    spi_sck,
	output logic                    spi_cs,
	output logic                    spi_mosi,
	input  logic                    spi_miso
);

	// Clock bus between divider and engine
	spi_sck_if sck_bus ();

	////////////////////////////////////////////////////////////
	// Conditional SCK divider
	////////////////////////////////////////////////////////////

	spi_sck_gen #(
		.DIV(DIV)
	) sck_gen0 (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.sck      (sck_bus.source)
	);

	////////////////////////////////////////////////////////////
	// Shift engine
	////////////////////////////////////////////////////////////

	spi_master #(
		.WIDTH(WIDTH)
	) master0 (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.trig     (trig),
		.data_in  (data_in),
		.data_out (data_out),
		.done     (done),
		.spi_cs   (spi_cs),
		.spi_mosi (spi_mosi),
		.spi_miso (spi_miso),
		.sck      (sck_bus.engine)
	);

	// Pin level comes straight from the divider
	assign spi_sck = sck_bus.sck;

endmodule

`default_nettype wire

// File: logic/spi_master.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_defs.svh"

module spi_master #(
	parameter int WIDTH = `SPI_WIDTH
) (
	input  logic                    CLK50MHZ,
	input  logic                    RST,

	// User side
	input  logic                    trig,
	input  spi_word_pkg::spi_word_t data_in,
	output spi_word_pkg::spi_word_t data_out,
	output logic                    done,

	// Serial lines
	output logic                    spi_cs,
	output logic                    spi_mosi,
	input  logic                    spi_miso,

	// Divider control and strobes
	spi_sck_if.engine               sck
);

	import spi_word_pkg::*;
	import spi_ctrl_pkg::*;

	spi_state_t       state;
	logic [WIDTH-1:0] shreg;
	spi_idx_t         bit_cnt;
	logic             start;
	logic             last_fall;

	////////////////////////////////////////////////////////////
	// Frame control
	////////////////////////////////////////////////////////////

	// Trigger only counts while idle
	assign start = (state == st_idle) && trig;

	// Falling edge that follows the last sampled bit
	assign last_fall = (state == st_shift) && sck.fall &&
		(bit_cnt == spi_idx_t'(WIDTH));

	// Divider stops in the very cycle of the last fall strobe,
	// so no extra SCK edge can follow even with a divider of one
	assign sck.run = (state == st_shift) && !last_fall;

	assign done = (state == st_done);

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					if (trig) begin
						state <= st_shift;
					end
				end
				st_shift: begin
					if (last_fall) begin
						state <= st_done;
					end
				end
				st_done: begin
					state <= st_idle;
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Bit counter
	////////////////////////////////////////////////////////////

	// Counts rise strobes, cleared outside a frame
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			bit_cnt <= '0;
		end else if (state != st_shift) begin
			bit_cnt <= '0;
		end else if (sck.rise) begin
			bit_cnt <= bit_cnt + spi_idx_t'(1);
		end
	end

	////////////////////////////////////////////////////////////
	// Shift register
	////////////////////////////////////////////////////////////

	// MSB feeds MOSI, MISO enters at the LSB on each rise
	always_ff @(posedge CLK50MHZ) begin
		if (start) begin
			shreg <= data_in[WIDTH-1:0];
		end else if ((state == st_shift) && sck.rise) begin
			shreg <= {shreg[WIDTH-2:0], spi_miso};
		end
	end

	// Received word, kept until the next frame ends
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			data_out <= '0;
		end else if (last_fall) begin
			data_out <= spi_word_t'(shreg);
		end
	end

	////////////////////////////////////////////////////////////
	// Serial outputs
	////////////////////////////////////////////////////////////

	// First bit goes out with CS, the rest on fall strobes
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			spi_mosi <= 1'b0;
		end else if (start) begin
			spi_mosi <= data_in[WIDTH-1];
		end else if ((state == st_shift) && sck.fall && !last_fall) begin
			spi_mosi <= shreg[WIDTH-1];
		end else if (state == st_done) begin
			spi_mosi <= 1'b0;
		end
	end

	// Chip select low from start until after the done cycle
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			spi_cs <= 1'b1;
		end else if (start) begin
			spi_cs <= 1'b0;
		end else if (state == st_done) begin
			spi_cs <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: logic/spi_sck_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_defs.svh"

module spi_sck_gen #(
	parameter int DIV = `SPI_DIV
) (
	input logic       CLK50MHZ,
	input logic       RST,
	spi_sck_if.source sck
);

	// Counter wide enough for DIV - 1, at least one bit
	localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DIV - 1);

	logic [CNT_W-1:0] cnt;
	logic             wrap;
	logic             level;
	logic             rise_q;
	logic             fall_q;

	// Half period is over
	assign wrap = (cnt == CNT_LAST);

	////////////////////////////////////////////////////////////
	// Half-period counter
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			cnt <= '0;
		end else if (!sck.run) begin
			cnt <= '0;
		end else if (wrap) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// SCK level and edge strobes
	////////////////////////////////////////////////////////////

	// Strobes are registered together with the toggle,
	// so they are high in the first cycle of the new level
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			level  <= 1'b0;
			rise_q <= 1'b0;
			fall_q <= 1'b0;
		end else if (!sck.run) begin
			// Idle low between frames
			level  <= 1'b0;
			rise_q <= 1'b0;
			fall_q <= 1'b0;
		end else if (wrap) begin
			level  <= ~level;
			rise_q <= ~level;
			fall_q <= level;
		end else begin
			rise_q <= 1'b0;
			fall_q <= 1'b0;
		end
	end

	assign sck.sck  = level;
	assign sck.rise = rise_q;
	assign sck.fall = fall_q;

endmodule

`default_nettype wire

// File: logic/spi_sck_if.sv
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////
// Serial clock bus between divider and shift engine
////////////////////////////////////////////////////////////

interface spi_sck_if;

	// Divider enable, high for the duration of a frame
	logic run;

	// Divided clock level
	logic sck;

	// One-cycle strobes, valid in the cycle sck changes
	logic rise;
	logic fall;

	// Clock divider side
	modport source (
		input  run,
		output sck,
		output rise,
		output fall
	);

	// Shift engine side
	modport engine (
		output run,
		input  sck,
		input  rise,
		input  fall
	);

endinterface

`default_nettype wire

// File: logic/spi_ctrl_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////
// Control types
////////////////////////////////////////////////////////////

package spi_ctrl_pkg;

	// Shift engine states
	typedef enum logic [1:0] {
		st_idle,
		st_shift,
		st_done
	} spi_state_t;

endpackage

`default_nettype wire

// File: logic/spi_word_pkg.sv
`default_nettype none

`include "spi_defs.svh"

////////////////////////////////////////////////////////////
// Data path types
////////////////////////////////////////////////////////////

package spi_word_pkg;

	// Parallel word as seen by the user side
	typedef logic [`SPI_WIDTH-1:0] spi_word_t;

	// Bit count within one frame
	typedef logic [`SPI_IDX_W-1:0] spi_idx_t;

endpackage

`default_nettype wire

// File: logic/spi_defs.svh
`ifndef SPI_DEFS_SVH
`define SPI_DEFS_SVH

////////////////////////////////////////////////////////////
// SPI master defaults
////////////////////////////////////////////////////////////

// Default parallel word width in bits
`define SPI_WIDTH 32

// System clocks per SCK half period
`define SPI_DIV 2

// Bit index width, room to count up to SPI_WIDTH + 1
`define SPI_IDX_W ($clog2(`SPI_WIDTH + 2))

`endif
